// File: design/dmem_pkg.sv
package dmem_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int DATA_WIDTH      = 64;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int DMEM_ADDR_WIDTH = 15;
  // The address bit just above the byte-in-line bits selects the bank
  localparam int LINE_ADDR_BITS  = 3;
  localparam int BANK_ADDR_WIDTH = DMEM_ADDR_WIDTH - LINE_ADDR_BITS - 1;

  // Broadcast message is word index, 4-bit strobe and a 32-bit word
  localparam int MSG_ADDR_WIDTH  = 10;
  localparam int MSG_WIDTH       = MSG_ADDR_WIDTH + 4 + 32;

  localparam int CMD_FIFO_DEPTH  = 4;
  localparam int RESP_FIFO_DEPTH = 8;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;
  typedef logic [DATA_WIDTH-1:0]      line_t;
  typedef logic [STRB_WIDTH-1:0]      strb_t;
  typedef logic [31:0]                word_t;

  // Broadcast region sits near the top of the data memory
  localparam dmem_addr_t BC_BASE_ADDR = 15'h7030;

  typedef struct packed {
    logic [MSG_ADDR_WIDTH-1:0] idx;
    logic [3:0]                strb;
    word_t                     data;
  } bc_msg_t;

  typedef struct packed {
    dmem_addr_t addr;
    strb_t      strb;
    line_t      data;
  } dma_wr_cmd_t;

  typedef struct packed {
    dmem_addr_t addr;
  } dma_rd_cmd_t;

endpackage

// File: design/dmem_access.sv
`timescale 1ns/100ps

// A bank-write request is taken in every cycle that en is high
interface mem_req_if;
  import dmem_pkg::*;

  logic       en;
  dmem_addr_t addr;
  strb_t      strb;
  line_t      data;

  modport src (output en, addr, strb, data);
  modport dst (input en, addr, strb, data);
endinterface

// The receiving side of this valid/ready channel also reports whether two more items fit
interface fifo_if #(
  parameter type payload_t = logic
);
  logic     valid;
  logic     ready;
  logic     has_room;
  payload_t payload;

  modport out (output valid, payload, input ready, has_room);
  modport in (input valid, payload, output ready, has_room);
endinterface

module dmem_access (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 core_dmem_en,
  input  logic                 core_dmem_wen,
  input  logic [3:0]           core_dmem_strb,
  input  logic                 core_dmem_swap,
  input  dmem_pkg::dmem_addr_t core_dmem_addr,
  input  dmem_pkg::word_t      core_dmem_wr_data,
  output dmem_pkg::word_t      core_dmem_rd_data,
  output logic                 core_dmem_rd_valid,

  mem_req_if.dst               bc_wr,
  fifo_if.in                   wr_q,
  fifo_if.in                   rd_q,
  fifo_if.out                  resp
);

  import dmem_pkg::*;

  dma_wr_cmd_t                wr_cmd;
  dma_rd_cmd_t                rd_cmd;
  logic [1:0]                 wr_gnt;
  logic [1:0]                 rd_gnt;
  logic [1:0]                 a_en;
  strb_t                      a_wen [2];
  logic [BANK_ADDR_WIDTH-1:0] a_addr [2];
  line_t                      a_wr_data [2];
  line_t                      a_rd_data [2];
  logic                       rd_gnt_r;
  logic                       rd_bank_r;

  strb_t                      core_strb_w;
  line_t                      core_data_w;
  logic [1:0]                 b_en;
  line_t                      b_rd_data [2];
  logic                       core_bank_r;
  logic [LINE_ADDR_BITS-3:0]  core_lane_r;
  logic                       core_swap_r;
  line_t                      core_line;
  word_t                      core_word;

  assign wr_cmd = wr_q.payload;
  assign rd_cmd = rd_q.payload;

  //////////////////////////////
  // DMA side, port a
  //////////////////////////////

  // Broadcast first, then the head write, then the head read if a response fits
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      a_en[b]      = 1'b0;
      wr_gnt[b]    = 1'b0;
      rd_gnt[b]    = 1'b0;
      a_wen[b]     = '0;
      a_addr[b]    = wr_cmd.addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
      a_wr_data[b] = wr_cmd.data;
      if (bc_wr.en && bc_wr.addr[LINE_ADDR_BITS] == 1'(b)) begin
        a_en[b]      = 1'b1;
        a_wen[b]     = bc_wr.strb;
        a_addr[b]    = bc_wr.addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
        a_wr_data[b] = bc_wr.data;
      end else if (wr_q.valid && wr_cmd.addr[LINE_ADDR_BITS] == 1'(b)) begin
        a_en[b]      = 1'b1;
        wr_gnt[b]    = 1'b1;
        a_wen[b]     = wr_cmd.strb;
      end else if (rd_q.valid && resp.has_room && rd_cmd.addr[LINE_ADDR_BITS] == 1'(b)) begin
        a_en[b]      = 1'b1;
        rd_gnt[b]    = 1'b1;
        a_addr[b]    = rd_cmd.addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
      end
    end
  end

  assign wr_q.ready    = |wr_gnt;
  assign rd_q.ready    = |rd_gnt;
  assign wr_q.has_room = 1'b1;
  assign rd_q.has_room = resp.has_room;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_gnt_r  <= 1'b0;
      rd_bank_r <= 1'b0;
    end else begin
      rd_gnt_r  <= |rd_gnt;
      rd_bank_r <= rd_gnt[1];
    end
  end

  // Bank data is ready the cycle after the grant
  assign resp.valid   = rd_gnt_r;
  assign resp.payload = rd_bank_r ? a_rd_data[1] : a_rd_data[0];

  //////////////////////////////
  // Core side, port b
  //////////////////////////////

  assign core_strb_w = strb_t'(core_dmem_strb) << {core_dmem_addr[LINE_ADDR_BITS-1:2], 2'b00};
  assign core_data_w = line_t'(core_dmem_wr_data)
                       << {core_dmem_addr[LINE_ADDR_BITS-1:2], 5'b00000};

  assign b_en[0] = core_dmem_en && !core_dmem_addr[LINE_ADDR_BITS];
  assign b_en[1] = core_dmem_en && core_dmem_addr[LINE_ADDR_BITS];

  // The core holds nothing for the read, so the lane and swap are kept here
  always_ff @(posedge clk) begin
    if (core_dmem_en && !core_dmem_wen) begin
      core_bank_r <= core_dmem_addr[LINE_ADDR_BITS];
      core_lane_r <= core_dmem_addr[LINE_ADDR_BITS-1:2];
      core_swap_r <= core_dmem_swap;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      core_dmem_rd_valid <= 1'b0;
    end else begin
      core_dmem_rd_valid <= core_dmem_en && !core_dmem_wen;
    end
  end

  assign core_line = core_bank_r ? b_rd_data[1] : b_rd_data[0];
  assign core_word = core_line[{core_lane_r, 5'b00000} +: 32];

  assign core_dmem_rd_data = core_swap_r ?
                             {core_word[7:0], core_word[15:8],
                              core_word[23:16], core_word[31:24]} :
                             core_word;

  for (genvar b = 0; b < 2; b++) begin : g_bank
    dmem_bank bank_i (
      .clk       (clk),
      .a_en      (a_en[b]),
      .a_wen     (a_wen[b]),
      .a_addr    (a_addr[b]),
      .a_wr_data (a_wr_data[b]),
      .a_rd_data (a_rd_data[b]),
      .b_en      (b_en[b]),
      .b_wen     (core_dmem_wen ? core_strb_w : strb_t'(0)),
      .b_addr    (core_dmem_addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1]),
      .b_wr_data (core_data_w),
      .b_rd_data (b_rd_data[b])
    );
  end

endmodule

// File: design/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst,

  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,

  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready,

  output logic     has_room
);

  payload_t                 mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH):0]   count;
  logic                     push;
  logic                     pop;

  assign in_ready  = count != ($clog2(DEPTH)+1)'(DEPTH);
  assign out_valid = count != '0;

  // Two free entries leave space for a push already in flight
  assign has_room  = count <= ($clog2(DEPTH)+1)'(DEPTH - 2);

  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap naturally since DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: design/dma_cmd_queue.sv
`timescale 1ns/100ps

module dma_cmd_queue (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 dma_cmd_wr_en,
  input  dmem_pkg::dmem_addr_t dma_cmd_wr_addr,
  input  dmem_pkg::line_t      dma_cmd_wr_data,
  input  dmem_pkg::strb_t      dma_cmd_wr_strb,
  output logic                 dma_cmd_wr_ready,

  input  logic                 dma_cmd_rd_en,
  input  dmem_pkg::dmem_addr_t dma_cmd_rd_addr,
  output logic                 dma_cmd_rd_ready,

  fifo_if.out                  wr_q,
  fifo_if.out                  rd_q
);

  import dmem_pkg::*;

  dma_wr_cmd_t wr_cmd;
  dma_rd_cmd_t rd_cmd;

  assign wr_cmd = '{addr: dma_cmd_wr_addr, strb: dma_cmd_wr_strb, data: dma_cmd_wr_data};
  assign rd_cmd = '{addr: dma_cmd_rd_addr};

  // Shallow queues spread bursts of DMA traffic over the bank arbiters
  sync_fifo #(
    .payload_t (dma_wr_cmd_t),
    .DEPTH     (CMD_FIFO_DEPTH)
  ) wr_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (dma_cmd_wr_en),
    .in_data   (wr_cmd),
    .in_ready  (dma_cmd_wr_ready),
    .out_valid (wr_q.valid),
    .out_data  (wr_q.payload),
    .out_ready (wr_q.ready),
    .has_room  ()
  );

  sync_fifo #(
    .payload_t (dma_rd_cmd_t),
    .DEPTH     (CMD_FIFO_DEPTH)
  ) rd_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (dma_cmd_rd_en),
    .in_data   (rd_cmd),
    .in_ready  (dma_cmd_rd_ready),
    .out_valid (rd_q.valid),
    .out_data  (rd_q.payload),
    .out_ready (rd_q.ready),
    .has_room  ()
  );

endmodule

// File: design/bc_msg_pipe.sv
`timescale 1ns/100ps

module bc_msg_pipe (
  input  logic                 clk,
  input  logic                 rst,

  input  dmem_pkg::bc_msg_t    bc_msg_in,
  input  logic                 bc_msg_in_valid,

  mem_req_if.src               bank_wr,

  output dmem_pkg::dmem_addr_t bc_msg_addr,
  output logic                 bc_msg_valid
);

  import dmem_pkg::*;

  bc_msg_t                   msg_r;
  logic                      valid_r;
  logic [LINE_ADDR_BITS-3:0] lane;

  dmem_addr_t                addr_rr;
  strb_t                     strb_rr;
  line_t                     data_rr;
  logic                      valid_rr;

  // Low index bits pick the 32-bit lane inside the line
  assign lane = msg_r.idx[LINE_ADDR_BITS-3:0];

  always_ff @(posedge clk) begin
    msg_r       <= bc_msg_in;
    addr_rr     <= BC_BASE_ADDR + DMEM_ADDR_WIDTH'({msg_r.idx, 2'b00});
    strb_rr     <= strb_t'(msg_r.strb) << {lane, 2'b00};
    data_rr     <= line_t'(msg_r.data) << {lane, 5'b00000};
    bc_msg_addr <= addr_rr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r      <= 1'b0;
      valid_rr     <= 1'b0;
      bc_msg_valid <= 1'b0;
    end else begin
      valid_r      <= bc_msg_in_valid;
      valid_rr     <= valid_r;
      bc_msg_valid <= valid_rr;
    end
  end

  // The write goes out from the second stage and always wins its bank
  assign bank_wr.en   = valid_rr;
  assign bank_wr.addr = addr_rr;
  assign bank_wr.strb = strb_rr;
  assign bank_wr.data = data_rr;

endmodule

// File: design/dmem_bank.sv
`timescale 1ns/100ps

module dmem_bank (
  input  logic                                 clk,

  input  logic                                 a_en,
  input  dmem_pkg::strb_t                      a_wen,
  input  logic [dmem_pkg::BANK_ADDR_WIDTH-1:0] a_addr,
  input  dmem_pkg::line_t                      a_wr_data,
  output dmem_pkg::line_t                      a_rd_data,

  input  logic                                 b_en,
  input  dmem_pkg::strb_t                      b_wen,
  input  logic [dmem_pkg::BANK_ADDR_WIDTH-1:0] b_addr,
  input  dmem_pkg::line_t                      b_wr_data,
  output dmem_pkg::line_t                      b_rd_data
);

  import dmem_pkg::*;

  line_t mem [2**BANK_ADDR_WIDTH];

  // Both ports are read-first with one cycle of read latency
  always @(posedge clk) begin
    if (a_en) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (a_wen[i]) begin
          mem[a_addr][i*8 +: 8] <= a_wr_data[i*8 +: 8];
        end
      end
      a_rd_data <= mem[a_addr];
    end
  end

  always @(posedge clk) begin
    if (b_en) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (b_wen[i]) begin
          mem[b_addr][i*8 +: 8] <= b_wr_data[i*8 +: 8];
        end
      end
      b_rd_data <= mem[b_addr];
    end
  end

endmodule

// File: design/dma_rd_resp.sv
`timescale 1ns/100ps

module dma_rd_resp (
  input  logic            clk,
  input  logic            rst,

  fifo_if.in              resp,

  output logic            dma_rd_resp_valid,
  output dmem_pkg::line_t dma_rd_resp_data,
  input  logic            dma_rd_resp_ready
);

  import dmem_pkg::*;

  // Read lines wait here in grant order while the DMA engine stalls.
  // The arbiter only grants a read while two entries are free, so the
  // push from the cycle after a grant always lands
  sync_fifo #(
    .payload_t (line_t),
    .DEPTH     (RESP_FIFO_DEPTH)
  ) resp_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (resp.valid),
    .in_data   (resp.payload),
    .in_ready  (resp.ready),
    .out_valid (dma_rd_resp_valid),
    .out_data  (dma_rd_resp_data),
    .out_ready (dma_rd_resp_ready),
    .has_room  (resp.has_room)
  );

endmodule

// File: design/dmem_sys.sv
`timescale 1ns/100ps

module dmem_sys (
  input  logic                           clk,
  input  logic                           rst,

  // DMA commands
  input  logic                           dma_cmd_wr_en,
  input  dmem_pkg::dmem_addr_t           dma_cmd_wr_addr,
  input  dmem_pkg::line_t                dma_cmd_wr_data,
  input  dmem_pkg::strb_t                dma_cmd_wr_strb,
  output logic                           dma_cmd_wr_ready,

  input  logic                           dma_cmd_rd_en,
  input  dmem_pkg::dmem_addr_t           dma_cmd_rd_addr,
  output logic                           dma_cmd_rd_ready,

  output logic                           dma_rd_resp_valid,
  output dmem_pkg::line_t                dma_rd_resp_data,
  input  logic                           dma_rd_resp_ready,

  // Core memory port
  input  logic                           core_dmem_en,
  input  logic                           core_dmem_wen,
  input  logic [3:0]                     core_dmem_strb,
  input  logic                           core_dmem_swap,
  input  dmem_pkg::dmem_addr_t           core_dmem_addr,
  input  dmem_pkg::word_t                core_dmem_wr_data,
  output dmem_pkg::word_t                core_dmem_rd_data,
  output logic                           core_dmem_rd_valid,

  // Broadcast messages
  input  logic [dmem_pkg::MSG_WIDTH-1:0] bc_msg_in,
  input  logic                           bc_msg_in_valid,
  output dmem_pkg::dmem_addr_t           bc_msg_addr,
  output logic                           bc_msg_valid
);

  import dmem_pkg::*;

  mem_req_if                       bc_wr_if ();
  fifo_if #(.payload_t(dma_wr_cmd_t)) wr_q_if ();
  fifo_if #(.payload_t(dma_rd_cmd_t)) rd_q_if ();
  fifo_if #(.payload_t(line_t))       resp_if ();

  dma_cmd_queue cmd_queue_i (
    .clk              (clk),
    .rst              (rst),
    .dma_cmd_wr_en    (dma_cmd_wr_en),
    .dma_cmd_wr_addr  (dma_cmd_wr_addr),
    .dma_cmd_wr_data  (dma_cmd_wr_data),
    .dma_cmd_wr_strb  (dma_cmd_wr_strb),
    .dma_cmd_wr_ready (dma_cmd_wr_ready),
    .dma_cmd_rd_en    (dma_cmd_rd_en),
    .dma_cmd_rd_addr  (dma_cmd_rd_addr),
    .dma_cmd_rd_ready (dma_cmd_rd_ready),
    .wr_q             (wr_q_if),
    .rd_q             (rd_q_if)
  );

  bc_msg_pipe bc_pipe_i (
    .clk             (clk),
    .rst             (rst),
    .bc_msg_in       (bc_msg_in),
    .bc_msg_in_valid (bc_msg_in_valid),
    .bank_wr         (bc_wr_if),
    .bc_msg_addr     (bc_msg_addr),
    .bc_msg_valid    (bc_msg_valid)
  );

  dmem_access access_i (
    .clk                (clk),
    .rst                (rst),
    .core_dmem_en       (core_dmem_en),
    .core_dmem_wen      (core_dmem_wen),
    .core_dmem_strb     (core_dmem_strb),
    .core_dmem_swap     (core_dmem_swap),
    .core_dmem_addr     (core_dmem_addr),
    .core_dmem_wr_data  (core_dmem_wr_data),
    .core_dmem_rd_data  (core_dmem_rd_data),
    .core_dmem_rd_valid (core_dmem_rd_valid),
    .bc_wr              (bc_wr_if),
    .wr_q               (wr_q_if),
    .rd_q               (rd_q_if),
    .resp               (resp_if)
  );

  dma_rd_resp rd_resp_i (
    .clk               (clk),
    .rst               (rst),
    .resp              (resp_if),
    .dma_rd_resp_valid (dma_rd_resp_valid),
    .dma_rd_resp_data  (dma_rd_resp_data),
    .dma_rd_resp_ready (dma_rd_resp_ready)
  );

endmodule

// File: test/tb_checks.svh
//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_line(input string name, input line_t got, input line_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic check_addr(input string name, input dmem_addr_t got, input dmem_addr_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic report_fail(input string msg);
  errors++;
  $display("%s", msg);
endtask

//////////////////////////////
// Memory model
//////////////////////////////

function automatic dmem_addr_t line_base(input dmem_addr_t a);
  return a & ~dmem_addr_t'(STRB_WIDTH - 1);
endfunction

function automatic dmem_addr_t word_base(input dmem_addr_t a);
  return a & ~dmem_addr_t'(3);
endfunction

// Broadcast words are packed four bytes apart above the region base
function automatic dmem_addr_t bc_word_addr(input logic [MSG_ADDR_WIDTH-1:0] idx);
  return dmem_addr_t'(int'(BC_BASE_ADDR) + 4 * int'(idx));
endfunction

// Strobe bit i covers byte base+i in little-endian order
function automatic void model_write(input dmem_addr_t base, input int n,
                                    input line_t data, input strb_t strb);
  for (int i = 0; i < n; i++) begin
    if (strb[i]) begin
      model_mem[base + dmem_addr_t'(i)]   = data[i*8 +: 8];
      model_known[base + dmem_addr_t'(i)] = 1'b1;
    end
  end
endfunction

// Bytes never written come back as zero with a zero mask
function automatic void model_read(input dmem_addr_t base, input int n,
                                   output line_t data, output line_t mask);
  data = '0;
  mask = '0;
  for (int i = 0; i < n; i++) begin
    if (model_known[base + dmem_addr_t'(i)]) begin
      data[i*8 +: 8] = model_mem[base + dmem_addr_t'(i)];
      mask[i*8 +: 8] = 8'hff;
    end
  end
endfunction

function automatic word_t byte_reverse(input word_t w);
  return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// File: test/tb_dmem_sys.sv
`timescale 1ns/100ps

module tb_dmem_sys;

  import dmem_pkg::*;

  localparam int N_DMA        = 24;
  localparam int N_CORE       = 48;
  localparam int N_BC         = 16;
  localparam int N_BP         = 24;
  localparam int N_CROSS      = 12;
  localparam int TOTAL_OPS    = 2*N_DMA + N_CORE + 4*N_BC + 2*N_BP + 4*N_CROSS;
  localparam int MAX_CYCLES   = TOTAL_OPS * 20 + 200;
  localparam int DRAIN_CYCLES = 2 * CMD_FIFO_DEPTH + 4;

  logic       clk;
  logic       rst;
  logic       dma_cmd_wr_en;
  dmem_addr_t dma_cmd_wr_addr;
  line_t      dma_cmd_wr_data;
  strb_t      dma_cmd_wr_strb;
  logic       dma_cmd_wr_ready;
  logic       dma_cmd_rd_en;
  dmem_addr_t dma_cmd_rd_addr;
  logic       dma_cmd_rd_ready;
  logic       dma_rd_resp_valid;
  line_t      dma_rd_resp_data;
  logic       dma_rd_resp_ready;
  logic       core_dmem_en;
  logic       core_dmem_wen;
  logic [3:0] core_dmem_strb;
  logic       core_dmem_swap;
  dmem_addr_t core_dmem_addr;
  word_t      core_dmem_wr_data;
  word_t      core_dmem_rd_data;
  logic       core_dmem_rd_valid;
  bc_msg_t    bc_msg_in;
  logic       bc_msg_in_valid;
  dmem_addr_t bc_msg_addr;
  logic       bc_msg_valid;

  logic [7:0] model_mem [2**DMEM_ADDR_WIDTH];
  bit         model_known [2**DMEM_ADDR_WIDTH];
  line_t      resp_exp_q [$];
  line_t      resp_mask_q [$];
  dmem_addr_t bc_exp_q [$];
  int         bc_due_q [$];
  dmem_addr_t addr_q [$];
  dmem_addr_t dma_lines_q [$];
  dmem_addr_t core_lines_q [$];
  bit         core_exp_valid;
  word_t      core_exp_word;
  word_t      core_exp_mask;
  bit         wr_acc;
  bit         rd_acc;
  bit         rd_stall_seen;
  int         wr_in_stall;
  int         bp_low_left;
  int         seed;
  int         cycle_no;
  int         errors;
  int         checks;
  int         tests_run;
  int         tests_bad;
  int         watchdog_cycles = 0;

  `include "tb_checks.svh"

  dmem_sys dut_i (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    watchdog_cycles <= watchdog_cycles + 1;
    if (watchdog_cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fffffff) % n;
  endfunction

  //////////////////////////////
  // Cycle step and monitors
  //////////////////////////////

  // Book what the coming rising edge takes, then check outputs at the falling edge
  task automatic next_cycle();
    line_t exp_line;
    line_t exp_mask;
    wr_acc = dma_cmd_wr_en && dma_cmd_wr_ready;
    rd_acc = dma_cmd_rd_en && dma_cmd_rd_ready;
    if (wr_acc) begin
      model_write(line_base(dma_cmd_wr_addr), 8, dma_cmd_wr_data, dma_cmd_wr_strb);
    end
    if (rd_acc) begin
      model_read(line_base(dma_cmd_rd_addr), 8, exp_line, exp_mask);
      resp_exp_q.push_back(exp_line);
      resp_mask_q.push_back(exp_mask);
    end
    if (dma_cmd_rd_en && !dma_cmd_rd_ready) begin
      rd_stall_seen = 1'b1;
    end
    if (wr_acc && !dma_cmd_rd_ready) begin
      wr_in_stall++;
    end
    if (dma_rd_resp_valid && dma_rd_resp_ready) begin
      if (resp_exp_q.size() == 0) begin
        report_fail("a DMA read response arrived with no read outstanding");
      end else begin
        exp_line = resp_exp_q.pop_front();
        exp_mask = resp_mask_q.pop_front();
        check_line("dma_rd_resp_data", dma_rd_resp_data & exp_mask, exp_line);
      end
    end
    if (core_dmem_en && core_dmem_wen) begin
      model_write(word_base(core_dmem_addr), 4, line_t'(core_dmem_wr_data),
                  strb_t'(core_dmem_strb));
    end
    core_exp_valid = core_dmem_en && !core_dmem_wen;
    if (core_exp_valid) begin
      model_read(word_base(core_dmem_addr), 4, exp_line, exp_mask);
      core_exp_word = core_dmem_swap ? byte_reverse(exp_line[31:0]) : exp_line[31:0];
      core_exp_mask = core_dmem_swap ? byte_reverse(exp_mask[31:0]) : exp_mask[31:0];
    end
    if (bc_msg_in_valid) begin
      model_write(bc_word_addr(bc_msg_in.idx), 4, line_t'(bc_msg_in.data),
                  strb_t'(bc_msg_in.strb));
      bc_exp_q.push_back(bc_word_addr(bc_msg_in.idx));
      bc_due_q.push_back(cycle_no + 3);
    end

    @(negedge clk);
    cycle_no++;

    if (core_exp_valid) begin
      if (core_dmem_rd_valid !== 1'b1) begin
        report_fail("core_dmem_rd_valid was low one cycle after a core read");
      end
      check_word("core_dmem_rd_data", core_dmem_rd_data & core_exp_mask, core_exp_word);
    end else if (core_dmem_rd_valid !== 1'b0) begin
      report_fail("core_dmem_rd_valid was high with no core read one cycle before");
    end
    if (bc_due_q.size() > 0 && bc_due_q[0] == cycle_no) begin
      if (bc_msg_valid !== 1'b1) begin
        report_fail("bc_msg_valid was low three cycles after a broadcast message");
      end
      check_addr("bc_msg_addr", bc_msg_addr, bc_exp_q.pop_front());
      bc_due_q.delete(0);
    end else if (bc_msg_valid !== 1'b0) begin
      report_fail("bc_msg_valid was high with no broadcast echo due");
    end

    dma_cmd_wr_en   = 1'b0;
    dma_cmd_rd_en   = 1'b0;
    core_dmem_en    = 1'b0;
    core_dmem_wen   = 1'b0;
    bc_msg_in_valid = 1'b0;
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  task automatic drive_dma_write(input int lo, input int span);
    dma_cmd_wr_en   = 1'b1;
    dma_cmd_wr_addr = dmem_addr_t'(lo + 8 * rand_below(span / 8));
    dma_cmd_wr_data = {$random(seed), $random(seed)};
    dma_cmd_wr_strb = strb_t'($random(seed));
  endtask

  // Each read stays on the bus until the command queue takes it
  task automatic issue_dma_reads();
    int i;
    i = 0;
    while (i < addr_q.size()) begin
      dma_cmd_rd_en   = 1'b1;
      dma_cmd_rd_addr = addr_q[i];
      next_cycle();
      if (rd_acc) begin
        i++;
      end
    end
  endtask

  // Mostly random, with an occasional long stretch held low
  task automatic set_resp_ready();
    if (bp_low_left > 0) begin
      bp_low_left--;
      dma_rd_resp_ready = 1'b0;
    end else if (rand_below(16) == 0) begin
      bp_low_left       = 12 + rand_below(16);
      dma_rd_resp_ready = 1'b0;
    end else begin
      dma_rd_resp_ready = rand_below(2) == 1;
    end
  endtask

  task automatic wait_responses(input bit random_ready);
    while (resp_exp_q.size() > 0) begin
      if (random_ready) begin
        set_resp_ready();
      end
      next_cycle();
    end
    dma_rd_resp_ready = 1'b1;
  endtask

  // Lets queued DMA writes and broadcast writes land before reads
  task automatic drain();
    repeat (DRAIN_CYCLES) next_cycle();
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    int err_start;
    int n;
    clk               = 1'b0;
    rst               = 1'b1;
    dma_cmd_wr_en     = 1'b0;
    dma_cmd_wr_addr   = '0;
    dma_cmd_wr_data   = '0;
    dma_cmd_wr_strb   = '0;
    dma_cmd_rd_en     = 1'b0;
    dma_cmd_rd_addr   = '0;
    dma_rd_resp_ready = 1'b1;
    core_dmem_en      = 1'b0;
    core_dmem_wen     = 1'b0;
    core_dmem_strb    = '0;
    core_dmem_swap    = 1'b0;
    core_dmem_addr    = '0;
    core_dmem_wr_data = '0;
    bc_msg_in         = '0;
    bc_msg_in_valid   = 1'b0;
    seed              = 32'hff413b39;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    err_start = errors;
    if (dma_cmd_wr_ready !== 1'b1 || dma_cmd_rd_ready !== 1'b1) begin
      report_fail("a DMA command ready level was not high after reset");
    end
    if (dma_rd_resp_valid !== 1'b0 || core_dmem_rd_valid !== 1'b0 || bc_msg_valid !== 1'b0) begin
      report_fail("a valid output was not low after reset");
    end
    finish_test("reset_state", err_start);

    err_start = errors;
    while (dma_lines_q.size() < N_DMA) begin
      drive_dma_write(32'h4000, 32'h2000);
      next_cycle();
      if (wr_acc) begin
        dma_lines_q.push_back(dma_cmd_wr_addr);
      end
    end
    drain();
    addr_q = dma_lines_q;
    issue_dma_reads();
    wait_responses(1'b0);
    finish_test("dma_write_read", err_start);

    err_start = errors;
    for (n = 0; n < N_CORE; n++) begin
      core_dmem_en      = 1'b1;
      core_dmem_wen     = (n < N_CORE / 4) || (rand_below(2) == 1);
      core_dmem_strb    = 4'($random(seed));
      core_dmem_swap    = rand_below(2) == 1;
      core_dmem_addr    = dmem_addr_t'(4 * rand_below(64));
      core_dmem_wr_data = $random(seed);
      next_cycle();
    end
    finish_test("core_access", err_start);

    // Broadcast writes run alongside DMA writes to the upper DMA region
    err_start = errors;
    addr_q.delete();
    for (n = 0; n < N_BC; n++) begin
      bc_msg_in_valid = 1'b1;
      bc_msg_in.idx   = MSG_ADDR_WIDTH'(rand_below(256));
      bc_msg_in.strb  = 4'($random(seed));
      bc_msg_in.data  = $random(seed);
      drive_dma_write(32'h6000, 32'h1000);
      next_cycle();
      if (wr_acc) begin
        addr_q.push_back(dma_cmd_wr_addr);
      end
      addr_q.push_back(line_base(bc_word_addr(bc_msg_in.idx)));
    end
    drain();
    issue_dma_reads();
    wait_responses(1'b0);
    finish_test("broadcast", err_start);

    err_start     = errors;
    rd_stall_seen = 1'b0;
    wr_in_stall   = 0;
    bp_low_left   = 40;
    n             = 0;
    while (n < N_BP) begin
      set_resp_ready();
      dma_cmd_rd_en   = 1'b1;
      dma_cmd_rd_addr = dma_lines_q[rand_below(dma_lines_q.size())];
      drive_dma_write(32'h6000, 32'h1000);
      next_cycle();
      if (rd_acc) begin
        n++;
      end
    end
    wait_responses(1'b1);
    if (!rd_stall_seen) begin
      report_fail("dma_cmd_rd_ready never dropped while responses were held back");
    end
    if (wr_in_stall == 0) begin
      report_fail("no DMA write was taken while read commands were backed up");
    end
    finish_test("back_pressure", err_start);

    err_start = errors;
    dma_lines_q.delete();
    for (n = 0; n < N_CROSS; n++) begin
      core_dmem_en      = 1'b1;
      core_dmem_wen     = 1'b1;
      core_dmem_strb    = 4'($random(seed));
      core_dmem_addr    = dmem_addr_t'(32'h1000 + 4 * rand_below(1024));
      core_dmem_wr_data = $random(seed);
      core_lines_q.push_back(line_base(core_dmem_addr));
      drive_dma_write(32'h4000, 32'h3000);
      next_cycle();
      if (wr_acc) begin
        dma_lines_q.push_back(dma_cmd_wr_addr);
      end
    end
    drain();
    foreach (dma_lines_q[i]) begin
      core_dmem_en   = 1'b1;
      core_dmem_swap = rand_below(2) == 1;
      core_dmem_addr = dma_lines_q[i] + dmem_addr_t'(4 * rand_below(2));
      next_cycle();
    end
    addr_q = core_lines_q;
    issue_dma_reads();
    wait_responses(1'b0);
    finish_test("cross_source", err_start);

    $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+test
design/dmem_pkg.sv
design/dmem_access.sv
design/sync_fifo.sv
design/dma_cmd_queue.sv
design/bc_msg_pipe.sv
design/dmem_bank.sv
design/dma_rd_resp.sv
design/dmem_sys.sv
test/tb_dmem_sys.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_dmem_sys
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
